// File: decodeExcChecker.sv
`timescale 1ns/1ps
`default_nettype none

module decodeExcChecker (
	excStageIf.consumer prev,
	excStageIf.producer out
);
	mipsIsaPkg::opcodeE opcode;
	mipsIsaPkg::functE  funct;
	logic               supported;
	logic               riGet;

	assign opcode = mipsIsaPkg::opcodeE'(prev.instr[31:26]);
	assign funct  = mipsIsaPkg::functE'(prev.instr[5:0]);

	// Membership in the supported subset
	always_comb
	begin
		case (opcode)
			mipsIsaPkg::SPECIAL:
			begin
				case (funct)
					mipsIsaPkg::JR,   mipsIsaPkg::ADD, mipsIsaPkg::ADDU,
					mipsIsaPkg::SUB,  mipsIsaPkg::SUBU, mipsIsaPkg::AND,
					mipsIsaPkg::OR,   mipsIsaPkg::SLT:
						supported = 1'b1;
					default:
						supported = 1'b0;
				endcase
			end
			mipsIsaPkg::J,    mipsIsaPkg::JAL,  mipsIsaPkg::BEQ,
			mipsIsaPkg::ADDI, mipsIsaPkg::ADDIU, mipsIsaPkg::ORI,
			mipsIsaPkg::LUI,  mipsIsaPkg::LB,   mipsIsaPkg::LH,
			mipsIsaPkg::LW,   mipsIsaPkg::LBU,  mipsIsaPkg::LHU,
			mipsIsaPkg::SB,   mipsIsaPkg::SH,   mipsIsaPkg::SW:
				supported = 1'b1;
			default:
				supported = 1'b0;
		endcase
	end

	// Only a clean, valid instruction can pick up RI here
	assign riGet = prev.valid && !prev.excGet && !supported;

	assign out.valid  = prev.valid;
	assign out.pc     = prev.pc;
	assign out.instr  = prev.instr;
	assign out.excGet = prev.excGet || riGet;

	always_comb
	begin
		if (prev.excGet)
			out.excCode = prev.excCode;
		else if (riGet)
			out.excCode = excPkg::RI;
		else
			out.excCode = excPkg::NONE;
	end
endmodule

`default_nettype wire

// File: excPipeline.sv
`timescale 1ns/1ps
`default_nettype none

`include "exc_macros.svh"

module excPipeline (
	input  logic                   clk,
	input  logic                   rstN,
	input  logic                   inValid,
	input  logic [`EXC_WORD_W-1:0] inPc,
	input  logic [`EXC_WORD_W-1:0] inInstr,
	input  logic                   overflow,
	input  logic [`EXC_WORD_W-1:0] memAddr,
	output logic                   commitValid,
	output logic                   commitExc,
	output logic [`EXC_CODE_W-1:0] commitCode,
	output logic [`EXC_WORD_W-1:0] commitPc
);
	// Decode, execute and memory registers, the commit register is the last edge
	localparam int numStageRegs = `EXC_PIPE_DEPTH - 1;

	// Index 0 fetch, 1 decode, 2 execute
	excStageIf chkOut [numStageRegs] ();
	// Index 0 decode, 1 execute, 2 memory
	excStageIf stageReg [numStageRegs] ();
	excStageIf memOut ();

	////////////////////////////////////////
	// Stage checkers
	////////////////////////////////////////
	fetchExcChecker fetchChk (
		.inPc    (inPc),
		.inInstr (inInstr),
		.inValid (inValid),
		.out     (chkOut[0])
	);

	decodeExcChecker decodeChk (
		.prev (stageReg[0]),
		.out  (chkOut[1])
	);

	executeExcChecker executeChk (
		.prev     (stageReg[1]),
		.overflow (overflow),
		.out      (chkOut[2])
	);

	memoryExcChecker memoryChk (
		.prev    (stageReg[2]),
		.memAddr (memAddr),
		.out     (memOut)
	);

	////////////////////////////////////////
	// Stage registers
	////////////////////////////////////////
	for (genvar i = 0; i < numStageRegs; i++)
	begin : genStage
		always_ff @(posedge clk or negedge rstN)
		begin
			if (!rstN)
			begin
				stageReg[i].valid   <= 1'b0;
				stageReg[i].excGet  <= 1'b0;
				stageReg[i].excCode <= excPkg::NONE;
			end
			else
			begin
				stageReg[i].valid   <= chkOut[i].valid;
				stageReg[i].excGet  <= chkOut[i].excGet;
				stageReg[i].excCode <= chkOut[i].excCode;
			end
		end

		always_ff @(posedge clk)
		begin
			stageReg[i].pc    <= chkOut[i].pc;
			stageReg[i].instr <= chkOut[i].instr;
		end
	end

	// Commit register
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			commitValid <= 1'b0;
			commitExc   <= 1'b0;
			commitCode  <= excPkg::NONE;
		end
		else
		begin
			commitValid <= memOut.valid;
			commitExc   <= memOut.excGet;
			commitCode  <= memOut.excCode;
		end
	end

	always_ff @(posedge clk)
	begin
		commitPc <= memOut.pc;
	end
endmodule

`default_nettype wire

// File: excPkg.sv
`default_nettype none

`include "exc_macros.svh"

package excPkg;

	// Cause codes raised along the pipeline
	typedef enum logic [`EXC_CODE_W-1:0] {
		NONE = 5'd0,
		// Address error on load or fetch
		ADEL = 5'd4,
		// Address error on store
		ADES = 5'd5,
		RI   = 5'd10,
		OV   = 5'd12
	} excCodeE;

endpackage

`default_nettype wire

// File: excScoreboard.sv
`timescale 1ns/1ps
`default_nettype none

`include "exc_macros.svh"

module excScoreboard (
	input  logic                   clk,
	input  logic                   rstN,
	input  logic                   inValid,
	input  logic [`EXC_WORD_W-1:0] inPc,
	input  logic [`EXC_WORD_W-1:0] inInstr,
	input  logic                   overflow,
	input  logic [`EXC_WORD_W-1:0] memAddr,
	input  logic                   commitValid,
	input  logic                   commitExc,
	input  logic [`EXC_CODE_W-1:0] commitCode,
	input  logic [`EXC_WORD_W-1:0] commitPc,
	input  int                     testId,
	input  logic                   testDone,
	output int                     errorCount,
	output int                     checkCount,
	output int                     testsRun,
	output int                     testsFailed
);
	localparam int depth = `EXC_PIPE_DEPTH;

	// Index 0 is the item sampled at the latest edge
	logic                   histValid [depth];
	logic [`EXC_WORD_W-1:0] histPc    [depth];
	logic [`EXC_WORD_W-1:0] histInstr [depth];
	logic                   histOv    [depth];

	logic                   expValid;
	logic [`EXC_WORD_W-1:0] expPc;
	excPkg::excCodeE        expCode;
	int                     errBase;
	int                     checkBase;

	function automatic string testName(input int id);
		case (id)
			0: return "idleAfterReset";
			1: return "misalignedPc";
			2: return "reservedInstr";
			3: return "overflowClass";
			4: return "memAlign";
			default: return "randomMix";
		endcase
	endfunction

	////////////////////////////////////////
	// Reference model
	////////////////////////////////////////
	function automatic excPkg::excCodeE predictCode(
		input logic                   valid,
		input logic [`EXC_WORD_W-1:0] pc,
		input logic [`EXC_WORD_W-1:0] instr,
		input logic                   ov,
		input logic [`EXC_WORD_W-1:0] addr
	);
		logic supported;
		logic canOv;
		logic isLoad;
		logic isStore;
		int   size;
		supported = 1'b1;
		canOv     = 1'b0;
		isLoad    = 1'b0;
		isStore   = 1'b0;
		size      = 1;
		case (instr[31:26])
			mipsIsaPkg::SPECIAL:
			begin
				case (instr[5:0])
					mipsIsaPkg::ADD, mipsIsaPkg::SUB:
						canOv = 1'b1;
					mipsIsaPkg::JR, mipsIsaPkg::ADDU, mipsIsaPkg::SUBU,
					mipsIsaPkg::AND, mipsIsaPkg::OR, mipsIsaPkg::SLT:
						supported = 1'b1;
					default:
						supported = 1'b0;
				endcase
			end
			mipsIsaPkg::ADDI:
				canOv = 1'b1;
			mipsIsaPkg::J, mipsIsaPkg::JAL, mipsIsaPkg::BEQ,
			mipsIsaPkg::ADDIU, mipsIsaPkg::ORI, mipsIsaPkg::LUI:
				supported = 1'b1;
			mipsIsaPkg::LB, mipsIsaPkg::LBU:
				isLoad = 1'b1;
			mipsIsaPkg::LH, mipsIsaPkg::LHU:
			begin
				isLoad = 1'b1;
				size   = 2;
			end
			mipsIsaPkg::LW:
			begin
				isLoad = 1'b1;
				size   = 4;
			end
			mipsIsaPkg::SB:
				isStore = 1'b1;
			mipsIsaPkg::SH:
			begin
				isStore = 1'b1;
				size    = 2;
			end
			mipsIsaPkg::SW:
			begin
				isStore = 1'b1;
				size    = 4;
			end
			default:
				supported = 1'b0;
		endcase

		// Earliest stage wins
		if (!valid)
			return excPkg::NONE;
		if (pc[1:0] != 2'b00)
			return excPkg::ADEL;
		if (!supported)
			return excPkg::RI;
		if (ov && canOv)
			return excPkg::OV;
		if (ov && isLoad)
			return excPkg::ADEL;
		if (ov && isStore)
			return excPkg::ADES;
		if ((isLoad || isStore) && (int'(addr[1:0]) % size) != 0)
			return isStore ? excPkg::ADES : excPkg::ADEL;
		return excPkg::NONE;
	endfunction

	task automatic compareField(
		input string                  field,
		input logic [`EXC_WORD_W-1:0] expVal,
		input logic [`EXC_WORD_W-1:0] actVal
	);
		checkCount++;
		if (actVal !== expVal)
		begin
			errorCount++;
			$display("[FAIL] %s %s expected 0x%0h actual 0x%0h",
				testName(testId), field, expVal, actVal);
		end
	endtask

	// Track each item and predict the one whose memory address is sampled now
	always @(posedge clk)
	begin
		if (!rstN)
		begin
			for (int i = 0; i < depth; i++)
				histValid[i] = 1'b0;
			expValid = 1'b0;
			expCode  = excPkg::NONE;
		end
		else
		begin
			for (int i = depth - 1; i > 0; i--)
			begin
				histValid[i] = histValid[i-1];
				histPc[i]    = histPc[i-1];
				histInstr[i] = histInstr[i-1];
				histOv[i]    = histOv[i-1];
			end
			histValid[0]     = inValid;
			histPc[0]        = inPc;
			histInstr[0]     = inInstr;
			histOv[depth-2]  = overflow;
			expValid = histValid[depth-1];
			expPc    = histPc[depth-1];
			expCode  = predictCode(histValid[depth-1], histPc[depth-1],
				histInstr[depth-1], histOv[depth-1], memAddr);
		end

		if (testDone)
		begin
			testsRun++;
			if (errorCount != errBase)
				testsFailed++;
			$display("Test %-15s %0d checks, %0d errors, %s", testName(testId),
				checkCount - checkBase, errorCount - errBase,
				(errorCount == errBase) ? "passed" : "failed");
			errBase   = errorCount;
			checkBase = checkCount;
		end
	end

	// Commit outputs are stable around the falling edge
	always @(negedge clk)
	begin
		if (rstN)
		begin
			compareField("commitValid", 32'(expValid), 32'(commitValid));
			compareField("commitExc", 32'(expCode != excPkg::NONE), 32'(commitExc));
			compareField("commitCode", 32'(expCode), 32'(commitCode));
			if (expValid)
				compareField("commitPc", expPc, commitPc);
		end
	end

	initial
	begin
		errorCount  = 0;
		checkCount  = 0;
		testsRun    = 0;
		testsFailed = 0;
		errBase     = 0;
		checkBase   = 0;
	end
endmodule

`default_nettype wire

// File: excStageIf.sv
`timescale 1ns/1ps
`default_nettype none

`include "exc_macros.svh"

// One instruction and the exception state it has picked up so far
interface excStageIf;
	logic                   valid;
	logic [`EXC_WORD_W-1:0] pc;
	logic [`EXC_WORD_W-1:0] instr;
	logic                   excGet;
	excPkg::excCodeE        excCode;

	modport producer (output valid, output pc, output instr, output excGet, output excCode);
	modport consumer (input valid, input pc, input instr, input excGet, input excCode);
endinterface

`default_nettype wire

// File: exc_macros.svh
`ifndef EXC_MACROS_SVH
`define EXC_MACROS_SVH

////////////////////////////////////////
// Fixed widths of the instruction set
////////////////////////////////////////

// Instruction and address width
`define EXC_WORD_W 32

// Cause code width, as in the MIPS Cause register
`define EXC_CODE_W 5

////////////////////////////////////////
// Pipeline timing
////////////////////////////////////////

// Sampling cycle plus three register edges up to commit
`define EXC_PIPE_DEPTH 4

`endif

// File: executeExcChecker.sv
`timescale 1ns/1ps
`default_nettype none

module executeExcChecker (
	excStageIf.consumer prev,
	input logic         overflow,
	excStageIf.producer out
);
	mipsIsaPkg::opcodeE opcode;
	mipsIsaPkg::functE  funct;
	logic               canOv;
	logic               isLoad;
	logic               isStore;
	logic               ovHit;

	assign opcode = mipsIsaPkg::opcodeE'(prev.instr[31:26]);
	assign funct  = mipsIsaPkg::functE'(prev.instr[5:0]);

	////////////////////////////////////////
	// Instruction class
	////////////////////////////////////////
	always_comb
	begin
		canOv   = 1'b0;
		isLoad  = 1'b0;
		isStore = 1'b0;
		case (opcode)
			mipsIsaPkg::SPECIAL:
			begin
				// Only the trapping forms of add and subtract
				if (funct == mipsIsaPkg::ADD || funct == mipsIsaPkg::SUB)
					canOv = 1'b1;
			end
			mipsIsaPkg::ADDI:
				canOv = 1'b1;
			mipsIsaPkg::LB, mipsIsaPkg::LBU, mipsIsaPkg::LH,
			mipsIsaPkg::LHU, mipsIsaPkg::LW:
				isLoad = 1'b1;
			mipsIsaPkg::SB, mipsIsaPkg::SH, mipsIsaPkg::SW:
				isStore = 1'b1;
			default:
				canOv = 1'b0;
		endcase
	end

	// For loads and stores the flag means address calculation overflow
	assign ovHit = prev.valid && !prev.excGet && overflow && (canOv || isLoad || isStore);

	assign out.valid  = prev.valid;
	assign out.pc     = prev.pc;
	assign out.instr  = prev.instr;
	assign out.excGet = prev.excGet || ovHit;

	always_comb
	begin
		if (prev.excGet)
			out.excCode = prev.excCode;
		else if (ovHit && canOv)
			out.excCode = excPkg::OV;
		else if (ovHit && isStore)
			out.excCode = excPkg::ADES;
		else if (ovHit)
			out.excCode = excPkg::ADEL;
		else
			out.excCode = excPkg::NONE;
	end
endmodule

`default_nettype wire

// File: fetchExcChecker.sv
`timescale 1ns/1ps
`default_nettype none

`include "exc_macros.svh"

module fetchExcChecker (
	input logic [`EXC_WORD_W-1:0] inPc,
	input logic [`EXC_WORD_W-1:0] inInstr,
	input logic                   inValid,
	excStageIf.producer           out
);
	logic pcMisaligned;

	// Instruction words sit on 4-byte boundaries
	assign pcMisaligned = inValid && (inPc[1:0] != 2'b00);

	assign out.valid  = inValid;
	assign out.pc     = inPc;
	assign out.instr  = inInstr;
	assign out.excGet = pcMisaligned;

	always_comb
	begin
		if (pcMisaligned)
			out.excCode = excPkg::ADEL;
		else
			out.excCode = excPkg::NONE;
	end
endmodule

`default_nettype wire

// File: flist.f
+incdir+.
mipsIsaPkg.sv
excPkg.sv
excStageIf.sv
fetchExcChecker.sv
decodeExcChecker.sv
executeExcChecker.sv
memoryExcChecker.sv
excPipeline.sv
excScoreboard.sv
tbExcPipeline.sv

// File: memoryExcChecker.sv
`timescale 1ns/1ps
`default_nettype none

`include "exc_macros.svh"

module memoryExcChecker (
	excStageIf.consumer           prev,
	input logic [`EXC_WORD_W-1:0] memAddr,
	excStageIf.producer           out
);
	mipsIsaPkg::opcodeE opcode;
	logic               isLoad;
	logic               isStore;
	logic               isWord;
	logic               isHalf;
	logic               misaligned;
	logic               alignHit;

	assign opcode = mipsIsaPkg::opcodeE'(prev.instr[31:26]);

	// Access direction and size
	always_comb
	begin
		isLoad  = 1'b0;
		isStore = 1'b0;
		isWord  = 1'b0;
		isHalf  = 1'b0;
		case (opcode)
			mipsIsaPkg::LW:
			begin
				isLoad = 1'b1;
				isWord = 1'b1;
			end
			mipsIsaPkg::LH, mipsIsaPkg::LHU:
			begin
				isLoad = 1'b1;
				isHalf = 1'b1;
			end
			mipsIsaPkg::LB, mipsIsaPkg::LBU:
				isLoad = 1'b1;
			mipsIsaPkg::SW:
			begin
				isStore = 1'b1;
				isWord  = 1'b1;
			end
			mipsIsaPkg::SH:
			begin
				isStore = 1'b1;
				isHalf  = 1'b1;
			end
			mipsIsaPkg::SB:
				isStore = 1'b1;
			default:
				isLoad = 1'b0;
		endcase
	end

	// Bytes are never misaligned
	assign misaligned = (isWord && (memAddr[1:0] != 2'b00)) || (isHalf && memAddr[0]);
	assign alignHit   = prev.valid && !prev.excGet && (isLoad || isStore) && misaligned;

	assign out.valid  = prev.valid;
	assign out.pc     = prev.pc;
	assign out.instr  = prev.instr;
	assign out.excGet = prev.excGet || alignHit;

	always_comb
	begin
		if (prev.excGet)
			out.excCode = prev.excCode;
		else if (alignHit && isStore)
			out.excCode = excPkg::ADES;
		else if (alignHit)
			out.excCode = excPkg::ADEL;
		else
			out.excCode = excPkg::NONE;
	end
endmodule

`default_nettype wire

// File: mipsIsaPkg.sv
`default_nettype none

package mipsIsaPkg;

	// Primary opcode field, instr[31:26]
	typedef enum logic [5:0] {
		SPECIAL = 6'h00,
		J       = 6'h02,
		JAL     = 6'h03,
		BEQ     = 6'h04,
		ADDI    = 6'h08,
		ADDIU   = 6'h09,
		ORI     = 6'h0d,
		LUI     = 6'h0f,
		LB      = 6'h20,
		LH      = 6'h21,
		LW      = 6'h23,
		LBU     = 6'h24,
		LHU     = 6'h25,
		SB      = 6'h28,
		SH      = 6'h29,
		SW      = 6'h2b
	} opcodeE;

	// Funct field under SPECIAL, instr[5:0]
	typedef enum logic [5:0] {
		JR   = 6'h08,
		ADD  = 6'h20,
		ADDU = 6'h21,
		SUB  = 6'h22,
		SUBU = 6'h23,
		AND  = 6'h24,
		OR   = 6'h25,
		SLT  = 6'h2a
	} functE;

endpackage

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# Build and run the exception pipeline testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal \
	-f flist.f \
	--top-module tbExcPipeline \
	-o simExcPipeline

./obj_dir/simExcPipeline | tee sim.log

if grep -qF "** PASS **" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi

// File: tbExcPipeline.sv
`timescale 1ns/1ps
`default_nettype none

`include "exc_macros.svh"

module tbExcPipeline;
	localparam int numTests      = 6;
	localparam int itemsPerTest  = 40;
	localparam int drainCycles   = `EXC_PIPE_DEPTH + 2;
	localparam int totalItems    = numTests * itemsPerTest;
	localparam int marginCycles  = numTests * (drainCycles + 2) + 40;
	localparam int timeoutCycles = totalItems + `EXC_PIPE_DEPTH + marginCycles;

	// Loads and stores sit at indices 8 to 15
	localparam logic [5:0] opList [16] = '{
		mipsIsaPkg::SPECIAL, mipsIsaPkg::J, mipsIsaPkg::JAL, mipsIsaPkg::BEQ,
		mipsIsaPkg::ADDI, mipsIsaPkg::ADDIU, mipsIsaPkg::ORI, mipsIsaPkg::LUI,
		mipsIsaPkg::LB, mipsIsaPkg::LH, mipsIsaPkg::LW, mipsIsaPkg::LBU,
		mipsIsaPkg::LHU, mipsIsaPkg::SB, mipsIsaPkg::SH, mipsIsaPkg::SW
	};
	localparam logic [5:0] functList [8] = '{
		mipsIsaPkg::JR, mipsIsaPkg::ADD, mipsIsaPkg::ADDU, mipsIsaPkg::SUB,
		mipsIsaPkg::SUBU, mipsIsaPkg::AND, mipsIsaPkg::OR, mipsIsaPkg::SLT
	};

	logic                   clk;
	logic                   rstN;
	logic                   inValid;
	logic [`EXC_WORD_W-1:0] inPc;
	logic [`EXC_WORD_W-1:0] inInstr;
	logic                   overflow;
	logic [`EXC_WORD_W-1:0] memAddr;
	logic                   commitValid;
	logic                   commitExc;
	logic [`EXC_CODE_W-1:0] commitCode;
	logic [`EXC_WORD_W-1:0] commitPc;
	int                     testId;
	logic                   testDone;
	int                     errorCount;
	int                     checkCount;
	int                     testsRun;
	int                     testsFailed;

	// Items of the current test
	logic                   itemValid [itemsPerTest];
	logic [`EXC_WORD_W-1:0] itemPc    [itemsPerTest];
	logic [`EXC_WORD_W-1:0] itemInstr [itemsPerTest];
	logic                   itemOv    [itemsPerTest];
	logic [`EXC_WORD_W-1:0] itemAddr  [itemsPerTest];

	always #5 clk = ~clk;

	excPipeline excPipeline_i (
		.clk         (clk),
		.rstN        (rstN),
		.inValid     (inValid),
		.inPc        (inPc),
		.inInstr     (inInstr),
		.overflow    (overflow),
		.memAddr     (memAddr),
		.commitValid (commitValid),
		.commitExc   (commitExc),
		.commitCode  (commitCode),
		.commitPc    (commitPc)
	);

	excScoreboard scoreboard (
		.clk         (clk),
		.rstN        (rstN),
		.inValid     (inValid),
		.inPc        (inPc),
		.inInstr     (inInstr),
		.overflow    (overflow),
		.memAddr     (memAddr),
		.commitValid (commitValid),
		.commitExc   (commitExc),
		.commitCode  (commitCode),
		.commitPc    (commitPc),
		.testId      (testId),
		.testDone    (testDone),
		.errorCount  (errorCount),
		.checkCount  (checkCount),
		.testsRun    (testsRun),
		.testsFailed (testsFailed)
	);

	////////////////////////////////////////
	// Stimulus generation
	////////////////////////////////////////
	function automatic logic [`EXC_WORD_W-1:0] validInstr(input int lowOp);
		logic [`EXC_WORD_W-1:0] instr;
		instr        = $urandom();
		instr[31:26] = opList[$urandom_range(lowOp, 15)];
		if (instr[31:26] == mipsIsaPkg::SPECIAL)
			instr[5:0] = functList[$urandom_range(0, 7)];
		return instr;
	endfunction

	function automatic logic [`EXC_WORD_W-1:0] anyInstr();
		if ($urandom_range(0, 1) == 0)
			return validInstr(0);
		return $urandom();
	endfunction

	task automatic makeItems(input int mode);
		for (int i = 0; i < itemsPerTest; i++)
		begin
			itemValid[i] = 1'b1;
			itemPc[i]    = $urandom();
			itemPc[i][1:0] = 2'b00;
			itemInstr[i] = anyInstr();
			itemOv[i]    = 1'($urandom_range(0, 1));
			itemAddr[i]  = $urandom();
			case (mode)
				0:
				begin
					itemValid[i]   = 1'b0;
					// Idle slots may carry any PC
					itemPc[i][1:0] = 2'($urandom_range(0, 3));
				end
				1:
					itemPc[i][1:0] = 2'($urandom_range(1, 3));
				2:
				begin
					itemInstr[i] = $urandom();
					// Reserved functs under SPECIAL now and then
					if ($urandom_range(0, 2) == 0)
						itemInstr[i][31:26] = mipsIsaPkg::SPECIAL;
				end
				3:
					itemInstr[i] = validInstr(0);
				4:
				begin
					itemInstr[i] = validInstr(8);
					itemOv[i]    = 1'b0;
				end
				default:
				begin
					itemValid[i] = ($urandom_range(0, 7) != 0);
					if ($urandom_range(0, 7) == 0)
						itemPc[i][1:0] = 2'($urandom_range(1, 3));
				end
			endcase
		end
	endtask

	// Issue one item per cycle, overflow two cycles later and memAddr three
	task automatic runItems();
		for (int c = 0; c < itemsPerTest + drainCycles; c++)
		begin
			@(posedge clk);
			#1;
			inValid  = (c < itemsPerTest) ? itemValid[c] : 1'b0;
			inPc     = (c < itemsPerTest) ? itemPc[c] : $urandom();
			inInstr  = (c < itemsPerTest) ? itemInstr[c] : $urandom();
			overflow = (c >= 2 && c - 2 < itemsPerTest) ? itemOv[c-2] : 1'($urandom_range(0, 1));
			memAddr  = (c >= 3 && c - 3 < itemsPerTest) ? itemAddr[c-3] : $urandom();
		end
	endtask

	task automatic finishTest();
		@(posedge clk);
		#1;
		testDone = 1'b1;
		@(posedge clk);
		#1;
		testDone = 1'b0;
	endtask

	initial
	begin
		#(timeoutCycles * 10);
		$display("Timeout: the run did not finish within %0d cycles", timeoutCycles);
		$display("** FAIL **");
		$finish;
	end

	initial
	begin
		clk      = 1'b0;
		rstN     = 1'b0;
		inValid  = 1'b0;
		inPc     = '0;
		inInstr  = '0;
		overflow = 1'b0;
		memAddr  = '0;
		testId   = 0;
		testDone = 1'b0;
		void'($urandom(89));

		repeat (4) @(posedge clk);
		#1;
		rstN = 1'b1;

		for (int t = 0; t < numTests; t++)
		begin
			testId = t;
			makeItems(t);
			runItems();
			finishTest();
		end

		@(posedge clk);
		#1;
		$display("Done: %0d of %0d tests failed, %0d errors in %0d checks",
			testsFailed, testsRun, errorCount, checkCount);
		if (errorCount == 0 && testsFailed == 0 && testsRun == numTests)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end
endmodule

`default_nettype wire
